// File: include/kernel_cu_defs.svh
// Kernel CU shared sizes
// Widths for requestor ports, the Wishbone bus and the done tracker
`ifndef KERNEL_CU_DEFS_SVH
`define KERNEL_CU_DEFS_SVH

// Requestors sharing the single memory port
`define KCU_NUM_REQUESTORS 2
`define KCU_ID_WIDTH 1

// Wishbone memory bus
`define KCU_ADDR_WIDTH 32
`define KCU_DATA_WIDTH 32
`define KCU_SEL_WIDTH 4

// Done condition must hold this many cycles before done_out
`define KCU_PULSE_HOLD 4
// Holds the worst-case number of requests inside the pipeline
`define KCU_MAX_INFLIGHT_WIDTH 3

`endif

// File: rtl/kernel_cu_pkg.sv
// Kernel CU package
// Request, response and requestor id types used along the memory pipeline
`include "kernel_cu_defs.svh"

package kernel_cu_pkg;

  // Index of the requestor that owns a transaction
  typedef logic [`KCU_ID_WIDTH-1:0] requestor_id_t;

  // One memory request as it travels from the arbiter to the bus
  typedef struct packed {
    requestor_id_t              id;
    logic                       we;
    logic [`KCU_ADDR_WIDTH-1:0] addr;
    logic [`KCU_DATA_WIDTH-1:0] data;
    logic [`KCU_SEL_WIDTH-1:0]  sel;
  } mem_request_t;

  // One memory response, routed back by id
  // Reads carry the bus data, writes carry zero
  typedef struct packed {
    requestor_id_t              id;
    logic [`KCU_DATA_WIDTH-1:0] data;
  } mem_response_t;

endpackage : kernel_cu_pkg

// File: rtl/pipe_slice.sv
// Pipeline register slice
// Two-entry skid buffer, registers both valid/data and ready
`timescale 1ns/1ps
`include "kernel_cu_defs.svh"

module pipe_slice #(
  parameter type payload_t = logic [`KCU_DATA_WIDTH-1:0]
) (
  input  logic     ap_clk,
  input  logic     areset_control,
  input  logic     in_valid,
  input  payload_t in_payload,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_payload,
  input  logic     out_ready
);

  // Second entry, only used while the output stalls
  logic     skid_valid;
  payload_t skid_payload;

  logic in_xfer;
  // Output register is free to take a new entry
  logic load_out;

  // Ready drops only once both entries hold data
  assign in_ready = ~skid_valid;
  assign in_xfer  = in_valid & in_ready;
  assign load_out = out_ready | ~out_valid;

  // ----------------------------------------------------------------------
  // Control
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (load_out) begin
      // Drain the skid entry first to keep order
      out_valid  <= skid_valid | in_xfer;
      skid_valid <= 1'b0;
    end else if (in_xfer) begin
      skid_valid <= 1'b1;
    end
  end

  // Payload path
  always_ff @(posedge ap_clk) begin
    if (load_out) begin
      out_payload <= skid_valid ? skid_payload : in_payload;
    end else if (in_xfer) begin
      skid_payload <= in_payload;
    end
  end

endmodule : pipe_slice

// File: rtl/request_arbiter.sv
// Request arbiter
// Round-robin merge of the requestor ports into one registered, id-tagged stream
`timescale 1ns/1ps
`include "kernel_cu_defs.svh"

module request_arbiter (
  input  logic                                                 ap_clk,
  input  logic                                                 areset_control,
  input  logic [`KCU_NUM_REQUESTORS-1:0]                       req_valid,
  input  logic [`KCU_NUM_REQUESTORS-1:0]                       req_we,
  input  logic [`KCU_NUM_REQUESTORS-1:0][`KCU_ADDR_WIDTH-1:0]  req_addr,
  input  logic [`KCU_NUM_REQUESTORS-1:0][`KCU_DATA_WIDTH-1:0]  req_data,
  input  logic [`KCU_NUM_REQUESTORS-1:0][`KCU_SEL_WIDTH-1:0]   req_sel,
  output logic [`KCU_NUM_REQUESTORS-1:0]                       req_ready,
  output logic                                                 arb_valid,
  output kernel_cu_pkg::mem_request_t                          arb_request,
  input  logic                                                 arb_ready
);

  // Requestor with first claim on the next grant
  kernel_cu_pkg::requestor_id_t rr_ptr;
  kernel_cu_pkg::requestor_id_t grant_id;
  kernel_cu_pkg::requestor_id_t next_ptr;
  logic                         grant_found;
  // Grant only while the output register is empty
  logic                         grant_ok;

  // ----------------------------------------------------------------------
  // Round-robin search starting at rr_ptr
  // ----------------------------------------------------------------------
  always_comb begin
    int idx;
    grant_found = 1'b0;
    grant_id    = '0;
    for (int k = 0; k < `KCU_NUM_REQUESTORS; k++) begin
      idx = (int'(rr_ptr) + k) % `KCU_NUM_REQUESTORS;
      if (!grant_found && req_valid[idx]) begin
        grant_found = 1'b1;
        grant_id    = kernel_cu_pkg::requestor_id_t'(idx);
      end
    end
  end

  assign grant_ok = grant_found & ~arb_valid;
  // Pointer moves past the winner so the other side wins a tie next time
  assign next_ptr = (grant_id == kernel_cu_pkg::requestor_id_t'(`KCU_NUM_REQUESTORS - 1)) ?
                    '0 : grant_id + 1'b1;

  always_comb begin
    for (int i = 0; i < `KCU_NUM_REQUESTORS; i++) begin
      req_ready[i] = grant_ok && (grant_id == kernel_cu_pkg::requestor_id_t'(i));
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      arb_valid <= 1'b0;
      rr_ptr    <= '0;
    end else if (arb_valid) begin
      arb_valid <= ~arb_ready;
    end else if (grant_ok) begin
      arb_valid <= 1'b1;
      rr_ptr    <= next_ptr;
    end
  end

  // Capture the winner and stamp its id
  always_ff @(posedge ap_clk) begin
    if (grant_ok) begin
      arb_request.id   <= grant_id;
      arb_request.we   <= req_we[grant_id];
      arb_request.addr <= req_addr[grant_id];
      arb_request.data <= req_data[grant_id];
      arb_request.sel  <= req_sel[grant_id];
    end
  end

endmodule : request_arbiter

// File: rtl/wb_master_port.sv
// Wishbone classic master port
// Issues one bus cycle per request and returns a tagged completion per acknowledge
`timescale 1ns/1ps
`include "kernel_cu_defs.svh"

module wb_master_port (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  logic                          iss_valid,
  input  kernel_cu_pkg::mem_request_t   iss_request,
  output logic                          iss_ready,
  output logic                          wb_cyc,
  output logic                          wb_stb,
  output logic                          wb_we,
  output logic [`KCU_ADDR_WIDTH-1:0]    wb_adr,
  output logic [`KCU_DATA_WIDTH-1:0]    wb_dat_w,
  output logic [`KCU_SEL_WIDTH-1:0]     wb_sel,
  input  logic [`KCU_DATA_WIDTH-1:0]    wb_dat_r,
  input  logic                          wb_ack,
  output logic                          cpl_valid,
  output kernel_cu_pkg::mem_response_t  cpl_response,
  input  logic                          cpl_ready
);

  // Idle, bus cycle open, completion waiting for the slice
  typedef enum logic [1:0] {ST_IDLE, ST_BUS, ST_HOLD} wb_state_t;

  wb_state_t                    state;
  // Owner of the open bus cycle
  kernel_cu_pkg::requestor_id_t cur_id;

  assign iss_ready = (state == ST_IDLE);
  assign wb_cyc    = (state == ST_BUS);
  assign wb_stb    = (state == ST_BUS);
  assign cpl_valid = (state == ST_HOLD);

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (iss_valid) state <= ST_BUS;
        ST_BUS:  if (wb_ack) state <= ST_HOLD;
        ST_HOLD: if (cpl_ready) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Bus outputs stay put for the whole cycle
  always_ff @(posedge ap_clk) begin
    if (iss_valid && iss_ready) begin
      cur_id   <= iss_request.id;
      wb_we    <= iss_request.we;
      wb_adr   <= iss_request.addr;
      wb_dat_w <= iss_request.data;
      wb_sel   <= iss_request.sel;
    end
  end

  // Writes complete with zero data
  always_ff @(posedge ap_clk) begin
    if (wb_cyc && wb_ack) begin
      cpl_response.id   <= cur_id;
      cpl_response.data <= wb_we ? '0 : wb_dat_r;
    end
  end

endmodule : wb_master_port

// File: rtl/response_router.sv
// Response router
// Steers each tagged response to the requestor named by its id
`timescale 1ns/1ps
`include "kernel_cu_defs.svh"

module response_router (
  input  logic                                                ret_valid,
  input  kernel_cu_pkg::mem_response_t                        ret_response,
  output logic                                                ret_ready,
  output logic [`KCU_NUM_REQUESTORS-1:0]                      rsp_valid,
  output logic [`KCU_NUM_REQUESTORS-1:0][`KCU_DATA_WIDTH-1:0] rsp_data,
  input  logic [`KCU_NUM_REQUESTORS-1:0]                      rsp_ready
);

  // ----------------------------------------------------------------------
  // Id decode, one valid at most
  // ----------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < `KCU_NUM_REQUESTORS; i++) begin
      rsp_valid[i] = ret_valid &&
                     (ret_response.id == kernel_cu_pkg::requestor_id_t'(i));
      // Data goes to every port, only the addressed one sees valid
      rsp_data[i]  = ret_response.data;
    end
  end

  // Back-pressure comes from the addressed requestor only
  assign ret_ready = rsp_ready[ret_response.id];

endmodule : response_router

// File: rtl/done_tracker.sv
// Done tracker
// Counts requests in flight and raises done_out once idle has held long enough
`timescale 1ns/1ps
`include "kernel_cu_defs.svh"

module done_tracker (
  input  logic                           ap_clk,
  input  logic                           areset_control,
  input  logic                           arb_valid,
  input  logic                           arb_ready,
  input  logic                           ret_valid,
  input  logic                           ret_ready,
  input  logic [`KCU_NUM_REQUESTORS-1:0] requestor_done,
  output logic                           done_out
);

  logic [`KCU_MAX_INFLIGHT_WIDTH-1:0] inflight;
  logic [`KCU_PULSE_HOLD-1:0]         done_hold;
  logic                               enter;
  logic                               leave;
  logic                               done_cond;

  // Requests past the arbiter register, and responses handed to the router
  assign enter = arb_valid & arb_ready;
  assign leave = ret_valid & ret_ready;

  // A request still sitting in the arbiter register also counts as busy
  assign done_cond = (&requestor_done) & (inflight == '0) & ~arb_valid;

  // ----------------------------------------------------------------------
  // In-flight count and hold window
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      inflight  <= '0;
      done_hold <= '0;
    end else begin
      inflight  <= inflight + enter - leave;
      done_hold <= {done_hold[`KCU_PULSE_HOLD-2:0], done_cond};
    end
  end

  assign done_out = &done_hold;

endmodule : done_tracker

// File: rtl/kernel_cu.sv
// Kernel CU memory-access core
// Arbiter, slice, Wishbone master, slice and router between two requestors and memory
`timescale 1ns/1ps
`include "kernel_cu_defs.svh"

module kernel_cu (
  input  logic                                                ap_clk,
  input  logic                                                areset_control,
  input  logic [`KCU_NUM_REQUESTORS-1:0]                      req_valid,
  input  logic [`KCU_NUM_REQUESTORS-1:0]                      req_we,
  input  logic [`KCU_NUM_REQUESTORS-1:0][`KCU_ADDR_WIDTH-1:0] req_addr,
  input  logic [`KCU_NUM_REQUESTORS-1:0][`KCU_DATA_WIDTH-1:0] req_data,
  input  logic [`KCU_NUM_REQUESTORS-1:0][`KCU_SEL_WIDTH-1:0]  req_sel,
  output logic [`KCU_NUM_REQUESTORS-1:0]                      req_ready,
  output logic [`KCU_NUM_REQUESTORS-1:0]                      rsp_valid,
  output logic [`KCU_NUM_REQUESTORS-1:0][`KCU_DATA_WIDTH-1:0] rsp_data,
  input  logic [`KCU_NUM_REQUESTORS-1:0]                      rsp_ready,
  input  logic [`KCU_NUM_REQUESTORS-1:0]                      requestor_done,
  output logic                                                wb_cyc,
  output logic                                                wb_stb,
  output logic                                                wb_we,
  output logic [`KCU_ADDR_WIDTH-1:0]                          wb_adr,
  output logic [`KCU_DATA_WIDTH-1:0]                          wb_dat_w,
  output logic [`KCU_SEL_WIDTH-1:0]                           wb_sel,
  input  logic [`KCU_DATA_WIDTH-1:0]                          wb_dat_r,
  input  logic                                                wb_ack,
  output logic                                                done_out
);

  // ----------------------------------------------------------------------
  // Request path, arbiter to bus
  // ----------------------------------------------------------------------
  logic                          arb_valid;
  logic                          arb_ready;
  kernel_cu_pkg::mem_request_t   arb_request;
  logic                          iss_valid;
  logic                          iss_ready;
  kernel_cu_pkg::mem_request_t   iss_request;

  // Response path, bus to router
  logic                          cpl_valid;
  logic                          cpl_ready;
  kernel_cu_pkg::mem_response_t  cpl_response;
  logic                          ret_valid;
  logic                          ret_ready;
  kernel_cu_pkg::mem_response_t  ret_response;

  request_arbiter inst_request_arbiter (
    .ap_clk, .areset_control,
    .req_valid, .req_we, .req_addr, .req_data, .req_sel, .req_ready,
    .arb_valid, .arb_request, .arb_ready
  );

  pipe_slice #(.payload_t(kernel_cu_pkg::mem_request_t)) inst_request_slice (
    .ap_clk, .areset_control,
    .in_valid (arb_valid), .in_payload (arb_request), .in_ready (arb_ready),
    .out_valid(iss_valid), .out_payload(iss_request), .out_ready(iss_ready)
  );

  wb_master_port inst_wb_master_port (
    .ap_clk, .areset_control,
    .iss_valid, .iss_request, .iss_ready,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack,
    .cpl_valid, .cpl_response, .cpl_ready
  );

  pipe_slice #(.payload_t(kernel_cu_pkg::mem_response_t)) inst_response_slice (
    .ap_clk, .areset_control,
    .in_valid (cpl_valid), .in_payload (cpl_response), .in_ready (cpl_ready),
    .out_valid(ret_valid), .out_payload(ret_response), .out_ready(ret_ready)
  );

  response_router inst_response_router (
    .ret_valid, .ret_response, .ret_ready,
    .rsp_valid, .rsp_data, .rsp_ready
  );

  // Watches the pipeline ends only
  done_tracker inst_done_tracker (
    .ap_clk, .areset_control,
    .arb_valid, .arb_ready, .ret_valid, .ret_ready,
    .requestor_done, .done_out
  );

endmodule : kernel_cu

// File: tests/kernel_cu_chk.sv
// Kernel CU handshake checker
// Concurrent assertions on the Wishbone master and the response ports
`timescale 1ns/1ps
`include "kernel_cu_defs.svh"

module kernel_cu_chk (
  input logic                                                ap_clk,
  input logic                                                areset_control,
  input logic                                                wb_cyc,
  input logic                                                wb_stb,
  input logic                                                wb_we,
  input logic [`KCU_ADDR_WIDTH-1:0]                          wb_adr,
  input logic [`KCU_DATA_WIDTH-1:0]                          wb_dat_w,
  input logic [`KCU_SEL_WIDTH-1:0]                           wb_sel,
  input logic                                                wb_ack,
  input logic [`KCU_NUM_REQUESTORS-1:0]                      rsp_valid,
  input logic [`KCU_NUM_REQUESTORS-1:0][`KCU_DATA_WIDTH-1:0] rsp_data,
  input logic [`KCU_NUM_REQUESTORS-1:0]                      rsp_ready
);

  // Failed assertions, summed into the testbench error count
  int assert_errors = 0;

  // Bus outputs hold until the slave acknowledges
  bus_stable: assert property (@(posedge ap_clk) disable iff (areset_control)
    wb_stb && !wb_ack |=> wb_stb && $stable({wb_we, wb_adr, wb_dat_w, wb_sel}))
    else begin
      $error("Wishbone outputs changed before acknowledge");
      assert_errors++;
    end

  stb_in_cyc: assert property (@(posedge ap_clk) disable iff (areset_control)
    wb_stb |-> wb_cyc)
    else begin
      $error("wb_stb high outside a bus cycle");
      assert_errors++;
    end

  // One response port at a time
  rsp_onehot: assert property (@(posedge ap_clk) disable iff (areset_control)
    $onehot0(rsp_valid))
    else begin
      $error("rsp_valid high for more than one requestor");
      assert_errors++;
    end

  // ----------------------------------------------------------------------
  // Response held with stable data until taken
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < `KCU_NUM_REQUESTORS; i++) begin : g_rsp
    rsp_hold: assert property (@(posedge ap_clk) disable iff (areset_control)
      rsp_valid[i] && !rsp_ready[i] |=> rsp_valid[i] && $stable(rsp_data[i]))
      else begin
        $error("Response to requestor %0d dropped or changed before rsp_ready", i);
        assert_errors++;
      end
  end

endmodule : kernel_cu_chk

// File: tests/kernel_cu_tb.sv
// Kernel CU testbench
// Directed tests with requestor drivers, a Wishbone memory model and response checks
`timescale 1ns/1ps
`include "kernel_cu_defs.svh"

module kernel_cu_tb;

  localparam int NREQ       = `KCU_NUM_REQUESTORS;
  localparam int CLK_PERIOD = 10;
  // Requests issued over all tests set the watchdog time
  localparam int TOTAL_REQS = 28;

  logic                                      ap_clk         = 1'b0;
  logic                                      areset_control = 1'b1;
  logic [NREQ-1:0]                           req_valid      = '0;
  logic [NREQ-1:0]                           req_we         = '0;
  logic [NREQ-1:0][`KCU_ADDR_WIDTH-1:0]      req_addr       = '0;
  logic [NREQ-1:0][`KCU_DATA_WIDTH-1:0]      req_data       = '0;
  logic [NREQ-1:0][`KCU_SEL_WIDTH-1:0]       req_sel        = '0;
  logic [NREQ-1:0]                           req_ready;
  logic [NREQ-1:0]                           rsp_valid;
  logic [NREQ-1:0][`KCU_DATA_WIDTH-1:0]      rsp_data;
  logic [NREQ-1:0]                           rsp_ready      = '1;
  logic [NREQ-1:0]                           requestor_done = '0;
  logic                                      wb_cyc;
  logic                                      wb_stb;
  logic                                      wb_we;
  logic [`KCU_ADDR_WIDTH-1:0]                wb_adr;
  logic [`KCU_DATA_WIDTH-1:0]                wb_dat_w;
  logic [`KCU_SEL_WIDTH-1:0]                 wb_sel;
  logic [`KCU_DATA_WIDTH-1:0]                wb_dat_r       = '0;
  logic                                      wb_ack         = 1'b0;
  logic                                      done_out;

  // Requests waiting for each driver, and the responses they must produce
  kernel_cu_pkg::mem_request_t  issue_q [NREQ][$];
  kernel_cu_pkg::mem_response_t exp_q   [NREQ][$];
  // Expected memory image and the bus-side memory
  logic [31:0] shadow [256];
  logic [31:0] mem    [256];
  logic [31:0] lcg_state = 32'h826f_c8d9;
  logic [1:0]  wait_left = '0;
  // Address range bit of each acknowledged bus cycle
  logic        bus_log [$];
  string       test_name = "reset";
  int          checks = 0;
  int          errors = 0;

  kernel_cu kernel_cu_i (.*);
  bind kernel_cu kernel_cu_chk chk_i (.*);

  always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Preload pattern that depends on every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
  endfunction

  // Byte lanes enabled in sel take the new data
  function automatic logic [31:0] apply_sel(input logic [31:0] old_word,
                                            input logic [31:0] new_word,
                                            input logic [3:0]  sel);
    logic [31:0] word;
    word = old_word;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        word[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return word;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int r = 0; r < NREQ; r++) begin
      n += issue_q[r].size() + exp_q[r].size();
    end
    return n;
  endfunction

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_response(input string test, input kernel_cu_pkg::mem_response_t exp,
                                input kernel_cu_pkg::mem_response_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected id %0d data %h, actual id %0d data %h",
               test, exp.id, exp.data, act.id, act.data);
    end
  endtask

  task automatic check_done(input string test, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected done_out %b, actual %b", test, exp, act);
    end
  endtask

  // Idle levels as {req_ready, rsp_valid, wb_cyc, done_out}
  task automatic check_level(input string test, input string what,
                             input logic [2*NREQ+1:0] exp, input logic [2*NREQ+1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: %s expected %b, actual %b", test, what, exp, act);
    end
  endtask

  // Queue one request and work out its response from the memory image
  task automatic issue(input int r, input logic we, input logic [31:0] addr,
                       input logic [31:0] data, input logic [3:0] sel);
    kernel_cu_pkg::mem_request_t  req;
    kernel_cu_pkg::mem_response_t exp;
    req.id   = kernel_cu_pkg::requestor_id_t'(r);
    req.we   = we;
    req.addr = addr;
    req.data = data;
    req.sel  = sel;
    exp.id   = req.id;
    exp.data = we ? '0 : shadow[addr[9:2]];
    if (we) begin
      shadow[addr[9:2]] = apply_sel(shadow[addr[9:2]], data, sel);
    end
    issue_q[r].push_back(req);
    exp_q[r].push_back(exp);
  endtask

  task automatic wait_drain();
    do begin
      @(negedge ap_clk);
    end while (pending() != 0 || req_valid != '0);
  endtask

  // ----------------------------------------------------------------------
  // Requestor drivers, memory model, response monitor
  // ----------------------------------------------------------------------
  always @(posedge ap_clk) begin : drive_requests
    kernel_cu_pkg::mem_request_t nxt;
    for (int r = 0; r < NREQ; r++) begin
      if (!areset_control && (!req_valid[r] || req_ready[r])) begin
        if (issue_q[r].size() > 0) begin
          nxt = issue_q[r].pop_front();
          req_valid[r] <= 1'b1;
          req_we[r]    <= nxt.we;
          req_addr[r]  <= nxt.addr;
          req_data[r]  <= nxt.data;
          req_sel[r]   <= nxt.sel;
        end else begin
          req_valid[r] <= 1'b0;
        end
      end
    end
  end

  // Acknowledge after 0 to 3 wait states
  always @(posedge ap_clk) begin : memory_model
    if (areset_control) begin
      wb_ack    <= 1'b0;
      wait_left <= '0;
      for (int i = 0; i < 256; i++) begin
        mem[i] <= fill_word(32'(i) << 2);
      end
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
    end else if (wb_stb && wait_left != '0) begin
      wait_left <= wait_left - 1'b1;
    end else if (wb_stb) begin
      wb_ack <= 1'b1;
      if (wb_we) begin
        mem[wb_adr[9:2]] <= apply_sel(mem[wb_adr[9:2]], wb_dat_w, wb_sel);
      end else begin
        wb_dat_r <= mem[wb_adr[9:2]];
      end
      bus_log.push_back(wb_adr[9]);
      lcg_state = lcg_next(lcg_state);
      wait_left <= lcg_state[17:16];
    end
  end

  always @(posedge ap_clk) begin : collect_responses
    kernel_cu_pkg::mem_response_t got;
    for (int r = 0; r < NREQ; r++) begin
      if (!areset_control && rsp_valid[r] && rsp_ready[r]) begin
        got.id   = kernel_cu_pkg::requestor_id_t'(r);
        got.data = rsp_data[r];
        if (exp_q[r].size() == 0) begin
          errors++;
          $display("%s: requestor %0d got a response with nothing outstanding", test_name, r);
        end else begin
          check_response(test_name, exp_q[r].pop_front(), got);
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic test_reset();
    test_name = "reset";
    @(posedge ap_clk);
    repeat (3) begin
      @(negedge ap_clk);
      check_level(test_name, "during reset", '0, {req_ready, rsp_valid, wb_cyc, done_out});
      @(posedge ap_clk);
    end
    areset_control <= 1'b0;
    repeat (2) begin
      @(negedge ap_clk);
      check_level(test_name, "after reset", '0, {req_ready, rsp_valid, wb_cyc, done_out});
    end
  endtask

  task automatic test_write_read();
    test_name = "write_read";
    @(negedge ap_clk);
    issue(0, 1'b1, 32'h0000_0040, 32'hcafe_f00d, 4'b1111);
    // Partial write touches bytes 0 and 2 only
    issue(0, 1'b1, 32'h0000_0040, 32'h1234_5678, 4'b0101);
    issue(0, 1'b0, 32'h0000_0040, '0, 4'b1111);
    wait_drain();
  endtask

  // Requestor 0 owns 0x000-0x1ff, requestor 1 owns 0x200-0x3ff
  task automatic test_concurrent();
    test_name = "concurrent";
    @(negedge ap_clk);
    bus_log.delete();
    for (int k = 0; k < 8; k++) begin
      issue(0, 1'b0, 32'h0000_0000 + 32'(k * 4), '0, '1);
      issue(1, 1'b0, 32'h0000_0200 + 32'(k * 4), '0, '1);
    end
    wait_drain();
    for (int k = 1; k < bus_log.size(); k++) begin
      if (bus_log[k] == bus_log[k-1]) begin
        errors++;
        $display("%s: range %0d took bus cycles %0d and %0d back to back while both waited",
                 test_name, bus_log[k], k - 1, k);
      end
    end
  endtask

  task automatic test_backpressure();
    test_name = "backpressure";
    @(posedge ap_clk);
    rsp_ready[1] <= 1'b0;
    @(negedge ap_clk);
    for (int k = 0; k < 4; k++) begin
      issue(1, 1'b0, 32'h0000_0280 + 32'(k * 4), '0, '1);
      issue(0, 1'b0, 32'h0000_0100 + 32'(k * 4), '0, '1);
    end
    // Stall long enough for the slices and the arbiter to fill
    repeat (40) @(negedge ap_clk);
    @(posedge ap_clk);
    rsp_ready[1] <= 1'b1;
    wait_drain();
  endtask

  task automatic test_done();
    test_name = "done";
    @(negedge ap_clk);
    check_done(test_name, 1'b0, done_out);
    @(posedge ap_clk);
    rsp_ready[0]   <= 1'b0;
    requestor_done <= '1;
    @(negedge ap_clk);
    issue(0, 1'b0, 32'h0000_0080, '0, '1);
    // One request stuck at the router keeps done_out low
    repeat (12) begin
      @(negedge ap_clk);
      check_done(test_name, 1'b0, done_out);
    end
    @(posedge ap_clk);
    rsp_ready[0] <= 1'b1;
    wait_drain();
    for (int k = 1; k <= `KCU_PULSE_HOLD; k++) begin
      @(negedge ap_clk);
      check_done(test_name, k == `KCU_PULSE_HOLD, done_out);
    end
    @(posedge ap_clk);
    requestor_done[1] <= 1'b0;
    @(negedge ap_clk);
    check_done(test_name, 1'b1, done_out);
    @(negedge ap_clk);
    check_done(test_name, 1'b0, done_out);
  endtask

  initial begin
    for (int i = 0; i < 256; i++) begin
      shadow[i] = fill_word(32'(i) << 2);
    end
    test_reset();
    test_write_read();
    test_concurrent();
    test_backpressure();
    test_done();
    $display("checks %0d, errors %0d, assertion errors %0d",
             checks, errors, kernel_cu_i.chk_i.assert_errors);
    if (errors == 0 && kernel_cu_i.chk_i.assert_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((200 * TOTAL_REQS + 1000) * CLK_PERIOD);
    $display("Watchdog expired, the tests did not finish in time");
    $display("** FAIL **");
    $finish;
  end

endmodule : kernel_cu_tb

// File: kernel_cu.f
+incdir+include
rtl/kernel_cu_pkg.sv
rtl/pipe_slice.sv
rtl/request_arbiter.sv
rtl/wb_master_port.sv
rtl/response_router.sv
rtl/done_tracker.sv
rtl/kernel_cu.sv
tests/kernel_cu_chk.sv
tests/kernel_cu_tb.sv

// File: Bender.yml
package:
  name: kernel_cu

export_include_dirs:
  - include

sources:
  - rtl/kernel_cu_pkg.sv
  - rtl/pipe_slice.sv
  - rtl/request_arbiter.sv
  - rtl/wb_master_port.sv
  - rtl/response_router.sv
  - rtl/done_tracker.sv
  - rtl/kernel_cu.sv
  - target: test
    files:
      - tests/kernel_cu_chk.sv
      - tests/kernel_cu_tb.sv
